// ==== design/chn_ahb_decode.sv ====
`timescale 1ns/1ps

module chn_ahb_decode #(
  parameter logic [chn_reg_pkg::ADDR_DEC_W-1:0] CHN_BASE_ADDR = 10'h090
) (
  input  logic                              hclk,
  input  logic                              hrst_n,
  input  logic                              hsel,
  input  logic [1:0]                        htrans,
  input  logic [chn_reg_pkg::DATA_W-1:0]    haddr,
  input  logic                              hwrite,
  output logic [chn_reg_pkg::NUM_REGS-1:0]  wr_sel,
  output logic [chn_reg_pkg::NUM_REGS-1:0]  rd_sel
);

  import chn_reg_pkg::*;

  logic                  xfer_vld;
  logic [ADDR_DEC_W-1:0] dec_addr;
  logic [NUM_REGS-1:0]   addr_hit;
  logic [NUM_REGS-1:0]   wr_nxt;
  logic [NUM_REGS-1:0]   rd_nxt;

  // IDLE and BUSY transfers are ignored
  assign xfer_vld = hsel & ((htrans == HTRANS_NONSEQ) | (htrans == HTRANS_SEQ));
  assign dec_addr = haddr[ADDR_DEC_W-1:0];

  always_comb begin
    addr_hit[REG_SARN]       = (dec_addr == CHN_BASE_ADDR + OFS_SARN);
    addr_hit[REG_DARN]       = (dec_addr == CHN_BASE_ADDR + OFS_DARN);
    addr_hit[REG_CTRL_A]     = (dec_addr == CHN_BASE_ADDR + OFS_CTRL_A);
    addr_hit[REG_CTRL_B]     = (dec_addr == CHN_BASE_ADDR + OFS_CTRL_B);
    addr_hit[REG_INT_MASK]   = (dec_addr == CHN_BASE_ADDR + OFS_INT_MASK);
    addr_hit[REG_INT_STATUS] = (dec_addr == CHN_BASE_ADDR + OFS_INT_STATUS);
    addr_hit[REG_INT_CLEAR]  = (dec_addr == CHN_BASE_ADDR + OFS_INT_CLEAR);
    addr_hit[REG_SOFT_REQ]   = (dec_addr == CHN_BASE_ADDR + OFS_SOFT_REQ);
    addr_hit[REG_CHN_EN]     = (dec_addr == CHN_BASE_ADDR + OFS_CHN_EN);
    addr_hit[REG_GRPLEN_EXT] = (dec_addr == CHN_BASE_ADDR + OFS_GRPLEN_EXT);
  end

  always_comb begin
    wr_nxt = addr_hit & {NUM_REGS{xfer_vld & hwrite}};
    rd_nxt = addr_hit & {NUM_REGS{xfer_vld & ~hwrite}};
    wr_nxt[REG_INT_STATUS] = 1'b0; // Status is read-only
    rd_nxt[REG_INT_CLEAR]  = 1'b0; // Clear and soft request are write-only
    rd_nxt[REG_SOFT_REQ]   = 1'b0;
  end

  // Selects are valid during the data phase
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      wr_sel <= '0;
      rd_sel <= '0;
    end else begin
      wr_sel <= wr_nxt;
      rd_sel <= rd_nxt;
    end
  end

endmodule

// ==== design/chn_cfg_regs.sv ====
`timescale 1ns/1ps

module chn_cfg_regs (
  input  logic                               hclk,
  input  logic                               hrst_n,
  input  logic [chn_reg_pkg::NUM_REGS-1:0]   wr_sel,
  input  logic [chn_reg_pkg::NUM_REGS-1:0]   rd_sel,
  input  logic [chn_reg_pkg::DATA_W-1:0]     wdata,
  input  logic                               chnen_clr,
  output logic [chn_reg_pkg::DATA_W-1:0]     sarn,
  output logic [chn_reg_pkg::DATA_W-1:0]     darn,
  output logic                               dgrpaddrc,
  output logic                               sgrpaddrc,
  output logic                               grpmc,
  output logic                               endlan,
  output logic                               srcdtlgc,
  output logic                               int_en,
  output logic [chn_reg_pkg::CHINTMDC_W-1:0] chintmdc,
  output logic [chn_reg_pkg::BLOCK_TL_W-1:0] block_tl,
  output logic [chn_reg_pkg::GROUP_LEN_W-1:0] group_len,
  output logic [chn_reg_pkg::INC_W-1:0]      sinc,
  output logic [chn_reg_pkg::INC_W-1:0]      dinc,
  output logic [chn_reg_pkg::TR_WIDTH_W-1:0] src_tr_width,
  output logic [chn_reg_pkg::TR_WIDTH_W-1:0] dst_tr_width,
  output logic [chn_reg_pkg::TRGTMDC_W-1:0]  trgtmdc,
  output logic [chn_reg_pkg::PROTCTL_W-1:0]  protctl,
  output logic                               chnen,
  output logic                               sfwtrg,
  output logic [chn_reg_pkg::DATA_W-1:0]     rdata
);

  import chn_reg_pkg::*;

  logic              cfg_wr_ok;
  logic [DATA_W-1:0] ctrl_a_rd;
  logic [DATA_W-1:0] ctrl_b_rd;
  logic [DATA_W-1:0] grplen_rd;
  logic [DATA_W-1:0] chn_en_rd;

  assign cfg_wr_ok = ~chnen; // Configuration is frozen while the channel runs

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sarn <= '0;
      darn <= '0;
    end else begin
      if (wr_sel[REG_SARN] && cfg_wr_ok)
        sarn <= wdata;
      if (wr_sel[REG_DARN] && cfg_wr_ok)
        darn <= wdata;
    end
  end

  // group_len is split over CTRL_A and GRPLEN_EXT
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      dgrpaddrc    <= 1'b0;
      sgrpaddrc    <= 1'b0;
      grpmc        <= 1'b0;
      chintmdc     <= '0;
      block_tl     <= '0;
      group_len    <= '0;
      sinc         <= '0;
      dinc         <= '0;
      src_tr_width <= '0;
      dst_tr_width <= '0;
    end else begin
      if (wr_sel[REG_CTRL_A] && cfg_wr_ok) begin
        dgrpaddrc    <= wdata[CA_DGRPADDRC];
        sgrpaddrc    <= wdata[CA_SGRPADDRC];
        grpmc        <= wdata[CA_GRPMC];
        chintmdc     <= wdata[CA_CHINTMDC_LSB +: CHINTMDC_W];
        block_tl     <= wdata[CA_BLOCK_TL_LSB +: BLOCK_TL_W];
        group_len[GRPLEN_LO_W-1:0] <= wdata[CA_GROUP_LEN_LSB +: GRPLEN_LO_W];
        sinc         <= wdata[CA_SINC_LSB +: INC_W];
        dinc         <= wdata[CA_DINC_LSB +: INC_W];
        src_tr_width <= wdata[CA_SRC_TR_WIDTH_LSB +: TR_WIDTH_W];
        dst_tr_width <= wdata[CA_DST_TR_WIDTH_LSB +: TR_WIDTH_W];
      end
      if (wr_sel[REG_GRPLEN_EXT] && cfg_wr_ok)
        group_len[GROUP_LEN_W-1:GRPLEN_LO_W] <= wdata[GE_GROUP_LEN_LSB +: GRPLEN_HI_W];
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      protctl  <= '0;
      endlan   <= 1'b0;
      srcdtlgc <= 1'b0;
      trgtmdc  <= '0;
      int_en   <= 1'b0;
    end else if (wr_sel[REG_CTRL_B] && cfg_wr_ok) begin
      protctl  <= wdata[CB_PROTCTL_LSB +: PROTCTL_W];
      endlan   <= wdata[CB_ENDLAN];
      srcdtlgc <= wdata[CB_SRCDTLGC];
      trgtmdc  <= wdata[CB_TRGTMDC_LSB +: TRGTMDC_W];
      int_en   <= wdata[CB_INT_EN];
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chnen  <= 1'b0;
      sfwtrg <= 1'b0;
    end else begin
      if (wr_sel[REG_CHN_EN])
        chnen <= wdata[CHN_EN_BIT]; // Software write beats the FSM clear
      else if (chnen_clr)
        chnen <= 1'b0;
      sfwtrg <= wr_sel[REG_SOFT_REQ] & wdata[SOFT_REQ_BIT];
    end
  end

  always_comb begin
    ctrl_a_rd = '0;
    ctrl_a_rd[CA_DGRPADDRC] = dgrpaddrc;
    ctrl_a_rd[CA_SGRPADDRC] = sgrpaddrc;
    ctrl_a_rd[CA_GRPMC]     = grpmc;
    ctrl_a_rd[CA_CHINTMDC_LSB +: CHINTMDC_W]    = chintmdc;
    ctrl_a_rd[CA_BLOCK_TL_LSB +: BLOCK_TL_W]    = block_tl;
    ctrl_a_rd[CA_GROUP_LEN_LSB +: GRPLEN_LO_W]  = group_len[GRPLEN_LO_W-1:0];
    ctrl_a_rd[CA_SINC_LSB +: INC_W]             = sinc;
    ctrl_a_rd[CA_DINC_LSB +: INC_W]             = dinc;
    ctrl_a_rd[CA_SRC_TR_WIDTH_LSB +: TR_WIDTH_W] = src_tr_width;
    ctrl_a_rd[CA_DST_TR_WIDTH_LSB +: TR_WIDTH_W] = dst_tr_width;
  end

  always_comb begin
    ctrl_b_rd = '0;
    ctrl_b_rd[CB_PROTCTL_LSB +: PROTCTL_W] = protctl;
    ctrl_b_rd[CB_ENDLAN]                   = endlan;
    ctrl_b_rd[CB_SRCDTLGC]                 = srcdtlgc;
    ctrl_b_rd[CB_TRGTMDC_LSB +: TRGTMDC_W] = trgtmdc;
    ctrl_b_rd[CB_INT_EN]                   = int_en;
  end

  always_comb begin
    grplen_rd = '0;
    grplen_rd[GE_GROUP_LEN_LSB +: GRPLEN_HI_W] = group_len[GROUP_LEN_W-1:GRPLEN_LO_W];
    chn_en_rd = '0;
    chn_en_rd[CHN_EN_BIT] = chnen;
  end

  // Selects are one-hot so the terms never overlap
  assign rdata = ({DATA_W{rd_sel[REG_SARN]}}       & sarn)      |
                 ({DATA_W{rd_sel[REG_DARN]}}       & darn)      |
                 ({DATA_W{rd_sel[REG_CTRL_A]}}     & ctrl_a_rd) |
                 ({DATA_W{rd_sel[REG_CTRL_B]}}     & ctrl_b_rd) |
                 ({DATA_W{rd_sel[REG_GRPLEN_EXT]}} & grplen_rd) |
                 ({DATA_W{rd_sel[REG_CHN_EN]}}     & chn_en_rd);

endmodule

// ==== design/chn_int_ctrl.sv ====
`timescale 1ns/1ps

module chn_int_ctrl (
  input  logic                             hclk,
  input  logic                             hrst_n,
  input  logic [chn_reg_pkg::NUM_REGS-1:0] wr_sel,
  input  logic [chn_reg_pkg::NUM_REGS-1:0] rd_sel,
  input  logic [chn_reg_pkg::DATA_W-1:0]   wdata,
  input  logic                             int_en,
  input  logic                             err_vld,
  input  logic                             tfr_vld,
  input  logic                             htfr_vld,
  input  logic                             trgetcmp_vld,
  output logic                             irq,
  output logic [chn_reg_pkg::DATA_W-1:0]   rdata
);

  import chn_reg_pkg::*;

  logic [NUM_INT-1:0] int_evt;
  logic [NUM_INT-1:0] int_mask;
  logic [NUM_INT-1:0] int_status;
  logic [NUM_INT-1:0] int_clr;
  logic [DATA_W-1:0]  mask_rd;
  logic [DATA_W-1:0]  status_rd;

  always_comb begin
    int_evt[INT_ERR]      = err_vld;
    int_evt[INT_TFR]      = tfr_vld;
    int_evt[INT_HTFR]     = htfr_vld;
    int_evt[INT_TRGETCMP] = trgetcmp_vld;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n)
      int_mask <= '0;
    else if (wr_sel[REG_INT_MASK])
      int_mask <= wdata[NUM_INT-1:0];
  end

  // Clear pulses last one cycle after the write
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n)
      int_clr <= '0;
    else if (wr_sel[REG_INT_CLEAR])
      int_clr <= wdata[NUM_INT-1:0];
    else
      int_clr <= '0;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n)
      int_status <= '0;
    else
      int_status <= (int_status & ~int_clr) | int_evt; // A new event beats a clear
  end

  assign irq = int_en & (|(int_status & int_mask));

  assign mask_rd   = {{(DATA_W-NUM_INT){1'b0}}, int_mask};
  assign status_rd = {{(DATA_W-NUM_INT){1'b0}}, int_status};

  assign rdata = ({DATA_W{rd_sel[REG_INT_MASK]}}   & mask_rd) |
                 ({DATA_W{rd_sel[REG_INT_STATUS]}} & status_rd);

endmodule

// ==== design/chn_reg_pkg.sv ====
package chn_reg_pkg;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam int ADDR_DEC_W = 10; // Low address bits seen by the decoder
  localparam int DATA_W     = 32;

  localparam logic [ADDR_DEC_W-1:0] OFS_SARN       = 10'h000;
  localparam logic [ADDR_DEC_W-1:0] OFS_DARN       = 10'h004;
  localparam logic [ADDR_DEC_W-1:0] OFS_CTRL_A     = 10'h008;
  localparam logic [ADDR_DEC_W-1:0] OFS_CTRL_B     = 10'h00c;
  localparam logic [ADDR_DEC_W-1:0] OFS_INT_MASK   = 10'h010;
  localparam logic [ADDR_DEC_W-1:0] OFS_INT_STATUS = 10'h014;
  localparam logic [ADDR_DEC_W-1:0] OFS_INT_CLEAR  = 10'h018;
  localparam logic [ADDR_DEC_W-1:0] OFS_SOFT_REQ   = 10'h01c;
  localparam logic [ADDR_DEC_W-1:0] OFS_CHN_EN     = 10'h020;
  localparam logic [ADDR_DEC_W-1:0] OFS_GRPLEN_EXT = 10'h024;

  // Bit positions in the one-hot select vectors
  localparam int REG_SARN       = 0;
  localparam int REG_DARN       = 1;
  localparam int REG_CTRL_A     = 2;
  localparam int REG_CTRL_B     = 3;
  localparam int REG_INT_MASK   = 4;
  localparam int REG_INT_STATUS = 5;
  localparam int REG_INT_CLEAR  = 6;
  localparam int REG_SOFT_REQ   = 7;
  localparam int REG_CHN_EN     = 8;
  localparam int REG_GRPLEN_EXT = 9;
  localparam int NUM_REGS       = 10;

  localparam int BLOCK_TL_W  = 12;
  localparam int GROUP_LEN_W = 6;
  localparam int GRPLEN_LO_W = 4; // Part of group_len held in CTRL_A
  localparam int GRPLEN_HI_W = GROUP_LEN_W - GRPLEN_LO_W;
  localparam int CHINTMDC_W  = 3;
  localparam int INC_W       = 2;
  localparam int TR_WIDTH_W  = 2;
  localparam int TRGTMDC_W   = 2;
  localparam int PROTCTL_W   = 4;

  localparam int CA_DGRPADDRC        = 31;
  localparam int CA_SGRPADDRC        = 29;
  localparam int CA_GRPMC            = 28;
  localparam int CA_CHINTMDC_LSB     = 24;
  localparam int CA_BLOCK_TL_LSB     = 12;
  localparam int CA_GROUP_LEN_LSB    = 8;
  localparam int CA_SINC_LSB         = 6;
  localparam int CA_DINC_LSB         = 4;
  localparam int CA_SRC_TR_WIDTH_LSB = 2;
  localparam int CA_DST_TR_WIDTH_LSB = 0;

  localparam int GE_GROUP_LEN_LSB = 0; // Carries group_len bits 5:4

  localparam int CB_PROTCTL_LSB = 15;
  localparam int CB_ENDLAN      = 14;
  localparam int CB_SRCDTLGC    = 13;
  localparam int CB_TRGTMDC_LSB = 1;
  localparam int CB_INT_EN      = 0;

  localparam int CHN_EN_BIT   = 0;
  localparam int SOFT_REQ_BIT = 0;

  // Same positions in mask, status and clear
  localparam int INT_ERR      = 0;
  localparam int INT_TFR      = 1;
  localparam int INT_HTFR     = 2;
  localparam int INT_TRGETCMP = 3;
  localparam int NUM_INT      = 4;

endpackage

// ==== design/chn_reg_top.sv ====
`timescale 1ns/1ps

module chn_reg_top #(
  parameter logic [chn_reg_pkg::ADDR_DEC_W-1:0] CHN_BASE_ADDR = 10'h090
) (
  input  logic                                hclk,
  input  logic                                hrst_n,
  input  logic                                hsel,
  input  logic [1:0]                          htrans,
  input  logic [chn_reg_pkg::DATA_W-1:0]      haddr,
  input  logic                                hwrite,
  input  logic [chn_reg_pkg::DATA_W-1:0]      hwdata,
  output logic [chn_reg_pkg::DATA_W-1:0]      hrdata,
  input  logic                                chnen_clr,
  input  logic                                err_vld,
  input  logic                                tfr_vld,
  input  logic                                htfr_vld,
  input  logic                                trgetcmp_vld,
  output logic [chn_reg_pkg::DATA_W-1:0]      sarn,
  output logic [chn_reg_pkg::DATA_W-1:0]      darn,
  output logic                                dgrpaddrc,
  output logic                                sgrpaddrc,
  output logic                                grpmc,
  output logic                                endlan,
  output logic                                srcdtlgc,
  output logic [chn_reg_pkg::CHINTMDC_W-1:0]  chintmdc,
  output logic [chn_reg_pkg::BLOCK_TL_W-1:0]  block_tl,
  output logic [chn_reg_pkg::GROUP_LEN_W-1:0] group_len,
  output logic [chn_reg_pkg::INC_W-1:0]       sinc,
  output logic [chn_reg_pkg::INC_W-1:0]       dinc,
  output logic [chn_reg_pkg::TR_WIDTH_W-1:0]  src_tr_width,
  output logic [chn_reg_pkg::TR_WIDTH_W-1:0]  dst_tr_width,
  output logic [chn_reg_pkg::TRGTMDC_W-1:0]   trgtmdc,
  output logic [chn_reg_pkg::PROTCTL_W-1:0]   protctl,
  output logic                                chnen,
  output logic                                sfwtrg,
  output logic                                irq
);

  import chn_reg_pkg::*;

  logic [NUM_REGS-1:0] wr_sel;
  logic [NUM_REGS-1:0] rd_sel;
  logic                int_en;
  logic [DATA_W-1:0]   cfg_rdata;
  logic [DATA_W-1:0]   int_rdata;

  chn_ahb_decode #(
    .CHN_BASE_ADDR (CHN_BASE_ADDR)
  ) u_decode (
    .hclk   (hclk),
    .hrst_n (hrst_n),
    .hsel   (hsel),
    .htrans (htrans),
    .haddr  (haddr),
    .hwrite (hwrite),
    .wr_sel (wr_sel),
    .rd_sel (rd_sel)
  );

  chn_cfg_regs u_cfg_regs (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .wdata        (hwdata), // Data phase write data goes straight to the registers
    .chnen_clr    (chnen_clr),
    .sarn         (sarn),
    .darn         (darn),
    .dgrpaddrc    (dgrpaddrc),
    .sgrpaddrc    (sgrpaddrc),
    .grpmc        (grpmc),
    .endlan       (endlan),
    .srcdtlgc     (srcdtlgc),
    .int_en       (int_en),
    .chintmdc     (chintmdc),
    .block_tl     (block_tl),
    .group_len    (group_len),
    .sinc         (sinc),
    .dinc         (dinc),
    .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width),
    .trgtmdc      (trgtmdc),
    .protctl      (protctl),
    .chnen        (chnen),
    .sfwtrg       (sfwtrg),
    .rdata        (cfg_rdata)
  );

  chn_int_ctrl u_int_ctrl (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .wdata        (hwdata),
    .int_en       (int_en),
    .err_vld      (err_vld),
    .tfr_vld      (tfr_vld),
    .htfr_vld     (htfr_vld),
    .trgetcmp_vld (trgetcmp_vld),
    .irq          (irq),
    .rdata        (int_rdata)
  );

  assign hrdata = cfg_rdata | int_rdata; // Each block returns zero when not selected

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the register block simulation with Verilator.
# The exit status of the simulation binary is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_chn_reg -f sim.f -o tb_chn_reg

./obj_dir/tb_chn_reg

// ==== sim.f ====
design/chn_reg_pkg.sv
design/chn_ahb_decode.sv
design/chn_cfg_regs.sv
design/chn_int_ctrl.sv
design/chn_reg_top.sv
verification/chn_reg_properties.sv
verification/tb_chn_reg.sv

// ==== verification/chn_reg_properties.sv ====
`timescale 1ns/1ps

module chn_reg_properties (
  input logic                            hclk,
  input logic                            hrst_n,
  input logic                            err_vld,
  input logic                            tfr_vld,
  input logic                            htfr_vld,
  input logic                            trgetcmp_vld,
  input logic [chn_reg_pkg::NUM_INT-1:0] int_status,
  input logic                            sfwtrg,
  input logic                            chnen,
  input logic [chn_reg_pkg::DATA_W-1:0]  sarn
);

  import chn_reg_pkg::*;

  a_err_set: assert property (@(posedge hclk) disable iff (!hrst_n)
    err_vld |=> int_status[INT_ERR]) else $error("Error status not set after its event");

  a_tfr_set: assert property (@(posedge hclk) disable iff (!hrst_n)
    tfr_vld |=> int_status[INT_TFR]) else $error("Transfer status not set after its event");

  a_htfr_set: assert property (@(posedge hclk) disable iff (!hrst_n)
    htfr_vld |=> int_status[INT_HTFR]) else $error("Half transfer status not set");

  a_trgetcmp_set: assert property (@(posedge hclk) disable iff (!hrst_n)
    trgetcmp_vld |=> int_status[INT_TRGETCMP]) else $error("Target complete status not set");

  // Soft request is a single cycle pulse
  a_sfwtrg_pulse: assert property (@(posedge hclk) disable iff (!hrst_n)
    sfwtrg |=> !sfwtrg) else $error("sfwtrg high for two cycles in a row");

  a_sarn_locked: assert property (@(posedge hclk) disable iff (!hrst_n)
    chnen |=> $stable(sarn)) else $error("sarn changed while the channel was enabled");

endmodule

bind chn_reg_top chn_reg_properties u_props (
  .hclk         (hclk),
  .hrst_n       (hrst_n),
  .err_vld      (err_vld),
  .tfr_vld      (tfr_vld),
  .htfr_vld     (htfr_vld),
  .trgetcmp_vld (trgetcmp_vld),
  .int_status   (u_int_ctrl.int_status),
  .sfwtrg       (sfwtrg),
  .chnen        (chnen),
  .sarn         (sarn)
);

// ==== verification/tb_chn_reg.sv ====
`timescale 1ns/1ps

module tb_chn_reg;

  import chn_reg_pkg::*;

  localparam logic [ADDR_DEC_W-1:0] BASE_ADDR = 10'h090;
  localparam int WAIT_LIMIT = 8; // Cycles a wait loop may spend

  logic                   hclk;
  logic                   hrst_n;
  logic                   hsel;
  logic [1:0]             htrans;
  logic [DATA_W-1:0]      haddr;
  logic                   hwrite;
  logic [DATA_W-1:0]      hwdata;
  logic [DATA_W-1:0]      hrdata;
  logic                   chnen_clr;
  logic                   err_vld;
  logic                   tfr_vld;
  logic                   htfr_vld;
  logic                   trgetcmp_vld;
  logic [DATA_W-1:0]      sarn;
  logic [DATA_W-1:0]      darn;
  logic                   dgrpaddrc;
  logic                   sgrpaddrc;
  logic                   grpmc;
  logic                   endlan;
  logic                   srcdtlgc;
  logic [CHINTMDC_W-1:0]  chintmdc;
  logic [BLOCK_TL_W-1:0]  block_tl;
  logic [GROUP_LEN_W-1:0] group_len;
  logic [INC_W-1:0]       sinc;
  logic [INC_W-1:0]       dinc;
  logic [TR_WIDTH_W-1:0]  src_tr_width;
  logic [TR_WIDTH_W-1:0]  dst_tr_width;
  logic [TRGTMDC_W-1:0]   trgtmdc;
  logic [PROTCTL_W-1:0]   protctl;
  logic                   chnen;
  logic                   sfwtrg;
  logic                   irq;

  logic [DATA_W-1:0] shadow [NUM_REGS]; // Model of what each register should hold

  chn_reg_top #(
    .CHN_BASE_ADDR (BASE_ADDR)
  ) UUT (
    .hclk (hclk), .hrst_n (hrst_n), .hsel (hsel), .htrans (htrans), .haddr (haddr),
    .hwrite (hwrite), .hwdata (hwdata), .hrdata (hrdata), .chnen_clr (chnen_clr),
    .err_vld (err_vld), .tfr_vld (tfr_vld), .htfr_vld (htfr_vld),
    .trgetcmp_vld (trgetcmp_vld), .sarn (sarn), .darn (darn), .dgrpaddrc (dgrpaddrc),
    .sgrpaddrc (sgrpaddrc), .grpmc (grpmc), .endlan (endlan), .srcdtlgc (srcdtlgc),
    .chintmdc (chintmdc), .block_tl (block_tl), .group_len (group_len), .sinc (sinc),
    .dinc (dinc), .src_tr_width (src_tr_width), .dst_tr_width (dst_tr_width),
    .trgtmdc (trgtmdc), .protctl (protctl), .chnen (chnen), .sfwtrg (sfwtrg), .irq (irq)
  );

  always #2 hclk = ~hclk;

  // Upper address bits lie outside the decoded range
  function automatic logic [DATA_W-1:0] reg_addr(input int idx);
    return 32'h4000_0000 | (32'(BASE_ADDR) + 32'(idx * 4));
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input int idx);
    case (idx)
      REG_SARN, REG_DARN:           return shadow[idx];
      REG_CTRL_A:                   return shadow[idx] & 32'hb7ff_ffff; // Bits 30 and 27 unused
      REG_CTRL_B:                   return shadow[idx] & 32'h0007_e007;
      REG_GRPLEN_EXT:               return shadow[idx] & 32'h0000_0003;
      REG_CHN_EN:                   return shadow[idx] & 32'h0000_0001;
      REG_INT_MASK, REG_INT_STATUS: return shadow[idx] & 32'h0000_000f;
      default:                      return '0; // Write-only and unmapped offsets
    endcase
  endfunction

  function automatic logic expected_irq();
    return shadow[REG_CTRL_B][0] & (|(shadow[REG_INT_STATUS][3:0] & shadow[REG_INT_MASK][3:0]));
  endfunction

  task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("Checks failed");
    $fatal(1, "Wait limit reached");
  endtask

  task automatic next_cycle();
    @(posedge hclk);
    #1;
  endtask

  // Address phase of a single NONSEQ transfer, returns in the data phase
  task automatic drive_addr(input logic [DATA_W-1:0] addr, input logic wr);
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = wr;
    next_cycle();
    hsel   = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
  endtask

  task automatic ahb_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
    drive_addr(addr, 1'b1);
    hwdata = data;
    next_cycle();
  endtask

  task automatic ahb_read(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
    drive_addr(addr, 1'b0);
    @(negedge hclk);
    data = hrdata;
    next_cycle();
  endtask

  task automatic write_reg(input int idx, input logic [DATA_W-1:0] data);
    ahb_write(reg_addr(idx), data);
    case (idx)
      REG_SARN, REG_DARN, REG_CTRL_A, REG_CTRL_B, REG_GRPLEN_EXT:
        if (!shadow[REG_CHN_EN][0])
          shadow[idx] = data;
      REG_INT_MASK, REG_CHN_EN:
        shadow[idx] = data;
      default: ;
    endcase
  endtask

  task automatic write_cfg_random();
    write_reg(REG_SARN, $urandom());
    write_reg(REG_DARN, $urandom());
    write_reg(REG_CTRL_A, $urandom());
    write_reg(REG_GRPLEN_EXT, $urandom());
    write_reg(REG_CTRL_B, $urandom());
  endtask

  task automatic check_reads();
    logic [DATA_W-1:0] data;
    for (int idx = 0; idx <= NUM_REGS; idx++) begin // One past the map is unmapped
      ahb_read(reg_addr(idx), data);
      check_eq($sformatf("hrdata at offset 0x%02h", idx * 4), data, expected_read(idx));
    end
  endtask

  task automatic check_cfg_outputs();
    logic [DATA_W-1:0] ca;
    logic [DATA_W-1:0] cb;
    logic [DATA_W-1:0] ge;
    ca = shadow[REG_CTRL_A];
    cb = shadow[REG_CTRL_B];
    ge = shadow[REG_GRPLEN_EXT];
    @(negedge hclk);
    check_eq("sarn", sarn, shadow[REG_SARN]);
    check_eq("darn", darn, shadow[REG_DARN]);
    check_eq("dgrpaddrc", 32'(dgrpaddrc), 32'(ca[31]));
    check_eq("sgrpaddrc", 32'(sgrpaddrc), 32'(ca[29]));
    check_eq("grpmc", 32'(grpmc), 32'(ca[28]));
    check_eq("chintmdc", 32'(chintmdc), 32'(ca[26:24]));
    check_eq("block_tl", 32'(block_tl), 32'(ca[23:12]));
    check_eq("group_len", 32'(group_len), 32'({ge[1:0], ca[11:8]}));
    check_eq("sinc", 32'(sinc), 32'(ca[7:6]));
    check_eq("dinc", 32'(dinc), 32'(ca[5:4]));
    check_eq("src_tr_width", 32'(src_tr_width), 32'(ca[3:2]));
    check_eq("dst_tr_width", 32'(dst_tr_width), 32'(ca[1:0]));
    check_eq("protctl", 32'(protctl), 32'(cb[18:15]));
    check_eq("endlan", 32'(endlan), 32'(cb[14]));
    check_eq("srcdtlgc", 32'(srcdtlgc), 32'(cb[13]));
    check_eq("trgtmdc", 32'(trgtmdc), 32'(cb[2:1]));
    next_cycle();
  endtask

  task automatic check_irq_now();
    @(negedge hclk);
    check_eq("irq", 32'(irq), 32'(expected_irq()));
    next_cycle();
  endtask

  task automatic pulse_event(input int int_bit);
    logic [DATA_W-1:0] data;
    err_vld      = (int_bit == INT_ERR);
    tfr_vld      = (int_bit == INT_TFR);
    htfr_vld     = (int_bit == INT_HTFR);
    trgetcmp_vld = (int_bit == INT_TRGETCMP);
    next_cycle();
    {err_vld, tfr_vld, htfr_vld, trgetcmp_vld} = '0;
    shadow[REG_INT_STATUS][int_bit] = 1'b1;
    ahb_read(reg_addr(REG_INT_STATUS), data);
    check_eq("int status", data, expected_read(REG_INT_STATUS));
  endtask

  // Clear pulse lives in cycle n+2, so status drops in cycle n+3
  task automatic clear_and_check(input logic [DATA_W-1:0] clr);
    logic [DATA_W-1:0] data;
    ahb_write(reg_addr(REG_INT_CLEAR), clr);
    @(negedge hclk);
    check_eq("irq before clear", 32'(irq), 32'(expected_irq()));
    shadow[REG_INT_STATUS] = shadow[REG_INT_STATUS] & ~clr;
    next_cycle();
    check_irq_now();
    ahb_read(reg_addr(REG_INT_STATUS), data);
    check_eq("int status after clear", data, expected_read(REG_INT_STATUS));
  endtask

  initial begin
    int cyc;
    hclk         = 1'b0;
    hrst_n       = 1'b0;
    hsel         = 1'b0;
    htrans       = 2'b00;
    haddr        = '0;
    hwrite       = 1'b0;
    hwdata       = '0;
    chnen_clr    = 1'b0;
    err_vld      = 1'b0;
    tfr_vld      = 1'b0;
    htfr_vld     = 1'b0;
    trgetcmp_vld = 1'b0;
    for (int i = 0; i < NUM_REGS; i++)
      shadow[i] = '0;
    void'($urandom(32'h49e6));
    repeat (8) @(posedge hclk);
    #1;
    hrst_n = 1'b1;

    @(negedge hclk);
    check_eq("chnen", 32'(chnen), 32'd0);
    check_eq("sfwtrg", 32'(sfwtrg), 32'd0);
    check_eq("irq", 32'(irq), 32'd0);
    next_cycle();
    check_cfg_outputs();
    check_reads();

    write_cfg_random();
    check_reads();
    check_cfg_outputs();

    write_reg(REG_CHN_EN, 32'h1);
    @(negedge hclk);
    check_eq("chnen", 32'(chnen), 32'd1);
    next_cycle();
    write_cfg_random(); // Locked, the model keeps the old values
    check_reads();
    check_cfg_outputs();
    chnen_clr = 1'b1;
    next_cycle();
    chnen_clr = 1'b0;
    shadow[REG_CHN_EN] = '0;
    @(negedge hclk);
    check_eq("chnen after clear", 32'(chnen), 32'd0);
    next_cycle();
    write_cfg_random();
    check_reads();
    check_cfg_outputs();

    write_reg(REG_CTRL_B, $urandom() | 32'h1);
    write_reg(REG_INT_MASK, 32'hf);
    for (int b = 0; b < NUM_INT; b++) begin
      pulse_event(b);
      check_irq_now();
    end
    write_reg(REG_INT_MASK, $urandom());
    check_irq_now();
    write_reg(REG_INT_MASK, 32'hf);
    clear_and_check($urandom() & 32'hf);
    clear_and_check(32'hf);
    pulse_event(INT_TFR);
    check_irq_now();
    write_reg(REG_CTRL_B, $urandom() & ~32'h1); // int_en low gates irq
    check_irq_now();
    check_reads();

    drive_addr(reg_addr(REG_SOFT_REQ), 1'b1);
    hwdata = $urandom() | 32'h1;
    cyc = 1;
    @(negedge hclk);
    while (sfwtrg !== 1'b1) begin
      if (cyc >= WAIT_LIMIT)
        report_timeout("sfwtrg");
      next_cycle();
      cyc++;
      @(negedge hclk);
    end
    check_eq("sfwtrg cycle", 32'(cyc), 32'd2);
    next_cycle();
    @(negedge hclk);
    check_eq("sfwtrg", 32'(sfwtrg), 32'd0);
    next_cycle();
    drive_addr(reg_addr(REG_SOFT_REQ), 1'b1);
    hwdata = $urandom() & ~32'h1;
    for (int k = 0; k < 4; k++) begin
      @(negedge hclk);
      check_eq("sfwtrg", 32'(sfwtrg), 32'd0);
      next_cycle();
    end

    $display("All checks passed");
    $finish;
  end

endmodule
